// ==== logic/isa_pkg.sv ====
//------------------------------------------------
// RV32I integer ALU subset only: OP, OP-IMM, LUI, AUIPC
// Branch, load/store and M encodings are absent
//------------------------------------------------

package isa_pkg;

  //------------------------------------------------
  // Widths with a meaning
  //------------------------------------------------

  typedef logic [31:0] word_t;     // Data or instruction word
  typedef logic [31:0] addr_t;     // Byte address
  typedef logic [4:0]  reg_idx_t;  // Architectural register index
  typedef logic [4:0]  shamt_t;    // Shift amount
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  //------------------------------------------------
  // Major opcodes
  //------------------------------------------------

  localparam opcode_t opc_op     = 7'b0110011;
  localparam opcode_t opc_op_imm = 7'b0010011;
  localparam opcode_t opc_lui    = 7'b0110111;
  localparam opcode_t opc_auipc  = 7'b0010111;

  // funct3, shared by OP and OP-IMM
  localparam funct3_t f3_add_sub = 3'b000;
  localparam funct3_t f3_sll     = 3'b001;
  localparam funct3_t f3_slt     = 3'b010;
  localparam funct3_t f3_sltu    = 3'b011;
  localparam funct3_t f3_xor     = 3'b100;
  localparam funct3_t f3_srl_sra = 3'b101;
  localparam funct3_t f3_or      = 3'b110;
  localparam funct3_t f3_and     = 3'b111;

  localparam funct7_t f7_base = 7'b0000000;
  localparam funct7_t f7_alt  = 7'b0100000;  // SUB, SRA, SRAI

  //------------------------------------------------
  // ALU functions
  //------------------------------------------------

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_pass_b,  // LUI
    alu_add_pc   // AUIPC
  } alu_op_t;

endpackage

// ==== logic/pipe_pkg.sv ====
//------------------------------------------------
// Records passed between the pipeline stages
// Every val is a one-cycle strobe, no ready
//------------------------------------------------

package pipe_pkg;

  // Fetch to decode
  typedef struct packed {
    logic           val;
    isa_pkg::addr_t pc;
    isa_pkg::word_t inst;
  } f_d_t;

  // Decode to execute, wen already cleared for x0 and unsupported
  typedef struct packed {
    logic              val;
    isa_pkg::addr_t    pc;
    isa_pkg::word_t    op_a;
    isa_pkg::word_t    op_b;
    isa_pkg::alu_op_t  alu_op;
    isa_pkg::reg_idx_t waddr;
    logic              wen;
  } d_x_t;

  // Execute to commit
  typedef struct packed {
    logic              val;
    isa_pkg::addr_t    pc;
    isa_pkg::reg_idx_t waddr;
    isa_pkg::word_t    wdata;
    logic              wen;
  } x_w_t;

  // Forwarding view, val only when a register is written
  typedef struct packed {
    logic              val;
    isa_pkg::reg_idx_t waddr;
    isa_pkg::word_t    wdata;
  } byp_t;

  //------------------------------------------------
  // Instruction trace record
  //------------------------------------------------

  typedef struct packed {
    isa_pkg::addr_t    pc;
    isa_pkg::reg_idx_t waddr;
    isa_pkg::word_t    wdata;
    logic              wen;
    logic              val;
  } trace_t;

endpackage

// ==== logic/fetch_stage.sv ====
//------------------------------------------------
// Issues one request per cycle, PC only ever +4
// Memory must answer exactly one cycle later
// p_reset_pc must be word aligned
//------------------------------------------------

module fetch_stage #(
  parameter isa_pkg::addr_t p_reset_pc = 32'h0000_0000
) (
  input  logic            clk,
  input  logic            arst_n,
  output logic            imem_req_val,
  output isa_pkg::addr_t  imem_req_addr,
  input  logic            imem_resp_val,
  input  isa_pkg::word_t  imem_resp_data,
  output pipe_pkg::f_d_t  f_d
);

  logic           req_val_q;
  isa_pkg::addr_t pc_q;       // Address on the request bus
  isa_pkg::addr_t resp_pc_q;  // PC of the outstanding request

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_val_q <= 1'b0;
      pc_q      <= p_reset_pc;
    end else begin
      req_val_q <= 1'b1;                     // No back-pressure, so never stops
      if (req_val_q) pc_q <= pc_q + 32'd4;   // Advance once a request left
    end
  end

  always_ff @(posedge clk) begin
    if (req_val_q) resp_pc_q <= pc_q;
  end

  assign imem_req_val  = req_val_q;
  assign imem_req_addr = pc_q;

  // Pair the response with its PC
  assign f_d = '{val: imem_resp_val, pc: resp_pc_q, inst: imem_resp_data};

  resp_after_req: assert property (@(posedge clk) disable iff (!arst_n)
    imem_resp_val |-> $past(imem_req_val));

endmodule

// ==== logic/decode_stage.sv ====
//------------------------------------------------
// Decodes the ALU subset, reads the register file
// Forwarding order: execute, then commit, then RF
// Unsupported encodings pass on as no-ops
//------------------------------------------------

module decode_stage (
  input  logic              clk,
  input  logic              arst_n,
  input  pipe_pkg::f_d_t    f_d,
  output isa_pkg::reg_idx_t rd_addr_a,
  output isa_pkg::reg_idx_t rd_addr_b,
  input  isa_pkg::word_t    rd_data_a,
  input  isa_pkg::word_t    rd_data_b,
  input  pipe_pkg::byp_t    byp_x,
  input  pipe_pkg::byp_t    byp_w,
  output pipe_pkg::d_x_t    d_x
);

  isa_pkg::opcode_t  opcode;
  isa_pkg::funct3_t  funct3;
  isa_pkg::funct7_t  funct7;
  isa_pkg::reg_idx_t rd;
  isa_pkg::word_t    imm_i;
  isa_pkg::word_t    imm_u;
  isa_pkg::word_t    src_a;
  isa_pkg::word_t    src_b;
  isa_pkg::alu_op_t  f3_op;
  isa_pkg::alu_op_t  alu_op;
  logic              supported;
  logic              use_imm;
  pipe_pkg::d_x_t    d_x_next;
  pipe_pkg::d_x_t    d_x_q;

  //------------------------------------------------
  // Fields and immediates
  //------------------------------------------------

  assign opcode    = f_d.inst[6:0];
  assign rd        = f_d.inst[11:7];
  assign funct3    = f_d.inst[14:12];
  assign rd_addr_a = f_d.inst[19:15];
  assign rd_addr_b = f_d.inst[24:20];
  assign funct7    = f_d.inst[31:25];

  assign imm_i = {{20{f_d.inst[31]}}, f_d.inst[31:20]};
  assign imm_u = {f_d.inst[31:12], 12'b0};

  // Same funct3 map for OP and OP-IMM
  always_comb begin
    case (funct3)
      isa_pkg::f3_add_sub: begin
        // Bit 30 is part of the immediate for ADDI
        f3_op = (opcode == isa_pkg::opc_op && funct7[5]) ? isa_pkg::alu_sub : isa_pkg::alu_add;
      end
      isa_pkg::f3_sll:     f3_op = isa_pkg::alu_sll;
      isa_pkg::f3_slt:     f3_op = isa_pkg::alu_slt;
      isa_pkg::f3_sltu:    f3_op = isa_pkg::alu_sltu;
      isa_pkg::f3_xor:     f3_op = isa_pkg::alu_xor;
      isa_pkg::f3_srl_sra: f3_op = funct7[5] ? isa_pkg::alu_sra : isa_pkg::alu_srl;
      isa_pkg::f3_or:      f3_op = isa_pkg::alu_or;
      default:             f3_op = isa_pkg::alu_and;
    endcase
  end

  always_comb begin
    alu_op    = f3_op;
    use_imm   = 1'b1;
    supported = 1'b0;
    case (opcode)
      isa_pkg::opc_op: begin
        use_imm   = 1'b0;
        supported = (funct7 == isa_pkg::f7_base) ||
                    (funct7 == isa_pkg::f7_alt &&
                     (funct3 == isa_pkg::f3_add_sub || funct3 == isa_pkg::f3_srl_sra));
      end
      isa_pkg::opc_op_imm: begin
        if (funct3 == isa_pkg::f3_sll)
          supported = (funct7 == isa_pkg::f7_base);
        else if (funct3 == isa_pkg::f3_srl_sra)
          supported = (funct7 == isa_pkg::f7_base) || (funct7 == isa_pkg::f7_alt);
        else
          supported = 1'b1;
      end
      isa_pkg::opc_lui: begin
        alu_op    = isa_pkg::alu_pass_b;
        supported = 1'b1;
      end
      isa_pkg::opc_auipc: begin
        alu_op    = isa_pkg::alu_add_pc;
        supported = 1'b1;
      end
      default: supported = 1'b0;  // Commits as a no-op
    endcase
  end

  //------------------------------------------------
  // Operand forwarding
  //------------------------------------------------

  function automatic isa_pkg::word_t fwd(isa_pkg::reg_idx_t idx, isa_pkg::word_t rf,
                                         pipe_pkg::byp_t bx, pipe_pkg::byp_t bw);
    if (bx.val && bx.waddr == idx)      return bx.wdata;  // Youngest first
    else if (bw.val && bw.waddr == idx) return bw.wdata;
    else                                return rf;
  endfunction

  assign src_a = fwd(rd_addr_a, rd_data_a, byp_x, byp_w);
  assign src_b = fwd(rd_addr_b, rd_data_b, byp_x, byp_w);

  assign d_x_next = '{
    val:    f_d.val,
    pc:     f_d.pc,
    op_a:   src_a,
    op_b:   !use_imm ? src_b : (opcode == isa_pkg::opc_op_imm) ? imm_i : imm_u,
    alu_op: alu_op,
    waddr:  rd,
    wen:    supported && (rd != '0)
  };

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      d_x_q <= '0;
    end else if (f_d.val) begin
      d_x_q <= d_x_next;
    end else begin
      d_x_q.val <= 1'b0;  // Data held, only the strobe drops
    end
  end

  assign d_x = d_x_q;

  no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
    (d_x.val && d_x.wen) |-> (d_x.waddr != '0));

endmodule

// ==== logic/alu_stage.sv ====
//------------------------------------------------
// Single-cycle ALU, result also feeds decode
// Shifts use only the low 5 bits of operand B
//------------------------------------------------

module alu_stage (
  input  logic           clk,
  input  logic           arst_n,
  input  pipe_pkg::d_x_t d_x,
  output pipe_pkg::byp_t byp_x,
  output pipe_pkg::x_w_t x_w
);

  isa_pkg::word_t  result;
  isa_pkg::shamt_t shamt;
  pipe_pkg::x_w_t  x_w_q;

  assign shamt = d_x.op_b[4:0];

  //------------------------------------------------
  // Execute
  //------------------------------------------------

  always_comb begin
    case (d_x.alu_op)
      isa_pkg::alu_add:    result = d_x.op_a + d_x.op_b;
      isa_pkg::alu_sub:    result = d_x.op_a - d_x.op_b;
      isa_pkg::alu_and:    result = d_x.op_a & d_x.op_b;
      isa_pkg::alu_or:     result = d_x.op_a | d_x.op_b;
      isa_pkg::alu_xor:    result = d_x.op_a ^ d_x.op_b;
      isa_pkg::alu_slt:    result = {31'b0, $signed(d_x.op_a) < $signed(d_x.op_b)};
      isa_pkg::alu_sltu:   result = {31'b0, d_x.op_a < d_x.op_b};
      isa_pkg::alu_sll:    result = d_x.op_a << shamt;
      isa_pkg::alu_srl:    result = d_x.op_a >> shamt;
      isa_pkg::alu_sra:    result = $signed(d_x.op_a) >>> shamt;  // Sign fill
      isa_pkg::alu_pass_b: result = d_x.op_b;
      isa_pkg::alu_add_pc: result = d_x.pc + d_x.op_b;
      default:             result = '0;
    endcase
  end

  // Only real register writes are visible to decode
  assign byp_x = '{
    val:   d_x.val && d_x.wen,
    waddr: d_x.waddr,
    wdata: result
  };

  //------------------------------------------------
  // Execute to commit register
  //------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      x_w_q <= '0;
    end else if (d_x.val) begin
      x_w_q <= '{
        val:   1'b1,
        pc:    d_x.pc,
        waddr: d_x.waddr,
        wdata: result,
        wen:   d_x.wen
      };
    end else begin
      x_w_q.val <= 1'b0;
    end
  end

  assign x_w = x_w_q;

endmodule

// ==== logic/commit_stage.sv ====
//------------------------------------------------
// Register file x1..x31, x0 reads as zero
// Reads are combinational, no write-through
// Trace is registered, one cycle after x_w
//------------------------------------------------

module commit_stage (
  input  logic              clk,
  input  logic              arst_n,
  input  pipe_pkg::x_w_t    x_w,
  input  isa_pkg::reg_idx_t rd_addr_a,
  input  isa_pkg::reg_idx_t rd_addr_b,
  output isa_pkg::word_t    rd_data_a,
  output isa_pkg::word_t    rd_data_b,
  output pipe_pkg::byp_t    byp_w,
  output pipe_pkg::trace_t  trace
);

  isa_pkg::word_t   rf [1:31];
  pipe_pkg::trace_t trace_q;

  //------------------------------------------------
  // Register file
  //------------------------------------------------

  always_ff @(posedge clk) begin
    if (x_w.val && x_w.wen) rf[x_w.waddr] <= x_w.wdata;
  end

  assign rd_data_a = (rd_addr_a == '0) ? '0 : rf[rd_addr_a];
  assign rd_data_b = (rd_addr_b == '0) ? '0 : rf[rd_addr_b];

  // Write in flight this cycle, lands at the next edge
  assign byp_w = '{
    val:   x_w.val && x_w.wen,
    waddr: x_w.waddr,
    wdata: x_w.wdata
  };

  //------------------------------------------------
  // Instruction trace
  //------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      trace_q <= '0;
    end else if (x_w.val) begin
      trace_q <= '{
        pc:    x_w.pc,
        waddr: x_w.waddr,
        wdata: x_w.wdata,
        wen:   x_w.wen,
        val:   1'b1
      };
    end else begin
      trace_q.val <= 1'b0;  // Last record held, strobe low
    end
  end

  assign trace = trace_q;

  // Traced write must come from a non-x0 destination upstream
  trace_no_x0: assert property (@(posedge clk) disable iff (!arst_n)
    (trace.val && trace.wen) |-> (trace.waddr != '0));

endmodule

// ==== logic/blimp_core.sv ====
//------------------------------------------------
// Four-stage in-order core, RV32I ALU subset only
// No stalls: imem must answer one cycle after req
// Trace follows its request by exactly 4 cycles
//------------------------------------------------

module blimp_core #(
  parameter isa_pkg::addr_t p_reset_pc = 32'h0000_0000
) (
  input  logic             clk,
  input  logic             arst_n,
  output logic             imem_req_val,
  output isa_pkg::addr_t   imem_req_addr,
  input  logic             imem_resp_val,
  input  isa_pkg::word_t   imem_resp_data,
  output pipe_pkg::trace_t inst_trace
);

  pipe_pkg::f_d_t    f_d;
  pipe_pkg::d_x_t    d_x;
  pipe_pkg::x_w_t    x_w;
  pipe_pkg::byp_t    byp_x;   // From execute
  pipe_pkg::byp_t    byp_w;   // From commit
  isa_pkg::reg_idx_t rd_addr_a;
  isa_pkg::reg_idx_t rd_addr_b;
  isa_pkg::word_t    rd_data_a;
  isa_pkg::word_t    rd_data_b;

  //------------------------------------------------
  // Stages
  //------------------------------------------------

  fetch_stage #(
    .p_reset_pc (p_reset_pc)
  ) fu (
    .clk            (clk),
    .arst_n         (arst_n),
    .imem_req_val   (imem_req_val),
    .imem_req_addr  (imem_req_addr),
    .imem_resp_val  (imem_resp_val),
    .imem_resp_data (imem_resp_data),
    .f_d            (f_d)
  );

  decode_stage diu (
    .clk       (clk),
    .arst_n    (arst_n),
    .f_d       (f_d),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .byp_x     (byp_x),
    .byp_w     (byp_w),
    .d_x       (d_x)
  );

  alu_stage alu_xu (
    .clk    (clk),
    .arst_n (arst_n),
    .d_x    (d_x),
    .byp_x  (byp_x),
    .x_w    (x_w)
  );

  commit_stage wcu (
    .clk       (clk),
    .arst_n    (arst_n),
    .x_w       (x_w),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .byp_w     (byp_w),
    .trace     (inst_trace)
  );

endmodule

// ==== tb/tb_clock_gen.sv ====
//------------------------------------------------
// Free-running clock, period 10
// arst_n held low for 4 cycles, released on a falling edge
//------------------------------------------------

module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  initial begin
    arst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;  // Away from the sampling edge
  end

endmodule

// ==== tb/blimp_core_tb.sv ====
//------------------------------------------------
// Random ALU-subset program from a fixed seed
// Memory answers one cycle after each request
// Stops at the first mismatch or a stalled core
//------------------------------------------------

module blimp_core_tb;

  localparam isa_pkg::addr_t reset_pc  = 32'h200;
  localparam int             prog_len  = 200;
  localparam isa_pkg::word_t nop_inst  = 32'h0000_0013;  // ADDI x0,x0,0

  logic             clk;
  logic             arst_n;
  logic             imem_req_val;
  isa_pkg::addr_t   imem_req_addr;
  logic             imem_resp_val;
  isa_pkg::word_t   imem_resp_data;
  pipe_pkg::trace_t inst_trace;

  isa_pkg::word_t   prog [0:prog_len-1];
  isa_pkg::word_t   model_rf [0:31];
  logic             pend_val;
  isa_pkg::addr_t   pend_addr;
  int unsigned      seed_rnd;

  tb_clock_gen clock_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  blimp_core #(
    .p_reset_pc (reset_pc)
  ) DUT (
    .clk            (clk),
    .arst_n         (arst_n),
    .imem_req_val   (imem_req_val),
    .imem_req_addr  (imem_req_addr),
    .imem_resp_val  (imem_resp_val),
    .imem_resp_data (imem_resp_data),
    .inst_trace     (inst_trace)
  );

  //------------------------------------------------
  // Failure reporting
  //------------------------------------------------

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "simulation stopped at time %0t", $time);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at time %0t: %s got %h expected %h", $time, name, got, exp);
      fail_run("DUT output mismatch");
    end
  endtask

  //------------------------------------------------
  // Program generation
  //------------------------------------------------

  // Small pool so results get reused right away, x0 often
  function automatic isa_pkg::reg_idx_t pick_reg();
    int unsigned rnd;
    rnd = $urandom;
    if (rnd[1:0] == 2'b00) return '0;
    return isa_pkg::reg_idx_t'(32'd1 + (rnd >> 2) % 32'd5);
  endfunction

  function automatic isa_pkg::word_t gen_inst();
    int unsigned       kind;
    int unsigned       rnd;
    int unsigned       imm;
    isa_pkg::reg_idx_t rd;
    isa_pkg::reg_idx_t rs1;
    isa_pkg::reg_idx_t rs2;
    logic [2:0]        f3;
    logic [4:0]        shamt;
    logic [6:0]        f7;
    logic [11:0]       imm12;
    isa_pkg::word_t    inst;
    kind  = $urandom % 20;
    rnd   = $urandom;
    imm   = $urandom;
    rd    = pick_reg();
    rs1   = pick_reg();
    rs2   = pick_reg();
    f3    = rnd[2:0];
    shamt = rnd[7:3];
    imm12 = imm[11:0];
    f7    = (rnd[8] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
    if (kind < 8) begin
      inst = {f7, rs2, rs1, f3, rd, isa_pkg::opc_op};
    end else if (kind < 15) begin
      if (f3 == 3'b001) imm12 = {7'h00, shamt};
      else if (f3 == 3'b101) imm12 = {f7, shamt};  // SRLI or SRAI
      inst = {imm12, rs1, f3, rd, isa_pkg::opc_op_imm};
    end else if (kind < 17) begin
      inst = {imm[31:12], rd, isa_pkg::opc_lui};
    end else if (kind == 17) begin
      inst = {imm[31:12], rd, isa_pkg::opc_auipc};
    end else begin
      // Outside the subset
      case (rnd[10:9])
        2'd0:    inst = {imm12, rs1, 3'b010, rd, 7'b0000011};          // LW
        2'd1:    inst = {7'h01, rs2, rs1, f3, rd, isa_pkg::opc_op};    // M extension
        default: inst = {7'h20, shamt, rs1, 3'b001, rd, isa_pkg::opc_op_imm};
      endcase
    end
    return inst;
  endfunction

  //------------------------------------------------
  // Reference model
  //------------------------------------------------

  function automatic isa_pkg::word_t expected_alu(logic [2:0] f3, logic alt,
                                                  isa_pkg::word_t a, isa_pkg::word_t b);
    logic [4:0]     sh;
    isa_pkg::word_t r;
    sh = b[4:0];
    case (f3)
      3'b000:  if (alt) r = a - b; else r = a + b;
      3'b001:  r = a << sh;
      3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  r = (a < b) ? 32'd1 : 32'd0;
      3'b100:  r = a ^ b;
      3'b101:  if (alt) r = $signed(a) >>> sh; else r = a >> sh;
      3'b110:  r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic pipe_pkg::trace_t step_model(isa_pkg::addr_t pc, isa_pkg::word_t inst);
    logic [6:0]        opcode;
    logic [2:0]        f3;
    logic [6:0]        f7;
    isa_pkg::reg_idx_t rd;
    isa_pkg::word_t    a;
    isa_pkg::word_t    b;
    isa_pkg::word_t    res;
    logic              ok;
    pipe_pkg::trace_t  t;
    opcode = inst[6:0];
    rd     = inst[11:7];
    f3     = inst[14:12];
    f7     = inst[31:25];
    a      = model_rf[inst[19:15]];
    b      = model_rf[inst[24:20]];
    res    = '0;
    ok     = 1'b0;
    case (opcode)
      7'b0110011: begin  // Register-register
        if (f7 == 7'h00) ok = 1'b1;
        else if (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)) ok = 1'b1;
        res = expected_alu(f3, f7 == 7'h20, a, b);
      end
      7'b0010011: begin  // Immediate forms
        b = {{20{inst[31]}}, inst[31:20]};
        if (f3 == 3'b001) ok = (f7 == 7'h00);
        else if (f3 == 3'b101) ok = (f7 == 7'h00) || (f7 == 7'h20);
        else ok = 1'b1;
        res = expected_alu(f3, f3 == 3'b101 && f7 == 7'h20, a, b);
      end
      7'b0110111: begin
        ok  = 1'b1;
        res = {inst[31:12], 12'h000};
      end
      7'b0010111: begin
        ok  = 1'b1;
        res = pc + {inst[31:12], 12'h000};
      end
      default: ok = 1'b0;
    endcase
    t.pc    = pc;
    t.waddr = rd;
    t.wdata = res;
    t.wen   = ok && (rd != '0);
    t.val   = 1'b1;
    if (t.wen) model_rf[rd] = res;  // x0 never written
    return t;
  endfunction

  //------------------------------------------------
  // Instruction memory, answers on the falling edge
  //------------------------------------------------

  function automatic isa_pkg::word_t imem_read(isa_pkg::addr_t addr);
    isa_pkg::addr_t offs;
    offs = addr - reset_pc;
    if (addr < reset_pc || (offs >> 2) >= prog_len) return nop_inst;
    return prog[offs >> 2];
  endfunction

  initial begin
    isa_pkg::addr_t next_addr;
    imem_resp_val  = 1'b0;
    imem_resp_data = '0;
    pend_val       = 1'b0;
    pend_addr      = '0;
    next_addr      = reset_pc;
    forever begin
      @(negedge clk);
      imem_resp_val  = pend_val;                         // Request from one cycle ago
      imem_resp_data = pend_val ? imem_read(pend_addr) : '0;
      if (arst_n === 1'b0) check_value("imem_req_val", {31'b0, imem_req_val}, 32'd0);
      // Requests walk the address space in steps of one word
      if (imem_req_val === 1'b1) begin
        check_value("imem_req_addr", imem_req_addr, next_addr);
        next_addr = next_addr + 32'd4;
      end
      pend_val       = (imem_req_val === 1'b1);
      pend_addr      = imem_req_addr;
    end
  end

  //------------------------------------------------
  // Waits
  //------------------------------------------------

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (arst_n !== 1'b1) begin
      @(posedge clk);
      if (arst_n === 1'b0) check_value("inst_trace.val", {31'b0, inst_trace.val}, 32'd0);
      cycles++;
      if (cycles > 20) fail_run("reset was never released");
    end
  endtask

  task automatic wait_commit();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (inst_trace.val !== 1'b1) begin
      cycles++;
      if (cycles >= 10) fail_run("core stopped committing instructions");
      @(negedge clk);
    end
  endtask

  //------------------------------------------------
  // Stimulus and trace checking
  //------------------------------------------------

  initial begin
    pipe_pkg::trace_t exp;
    seed_rnd = $urandom(32'he884);
    for (int r = 0; r < 32; r++) model_rf[r] = '0;
    // Give every pool register a value before any read
    for (int r = 1; r <= 5; r++) begin
      seed_rnd   = $urandom;
      prog[r-1] = {seed_rnd[11:0], 5'd0, 3'b000, isa_pkg::reg_idx_t'(r), isa_pkg::opc_op_imm};
    end
    for (int i = 5; i < prog_len; i++) prog[i] = gen_inst();

    wait_reset_release();
    for (int n = 0; n < prog_len; n++) begin
      wait_commit();
      exp = step_model(reset_pc + isa_pkg::addr_t'(4 * n), prog[n]);
      check_value("inst_trace.pc", inst_trace.pc, exp.pc);
      check_value("inst_trace.wen", {31'b0, inst_trace.wen}, {31'b0, exp.wen});
      check_value("inst_trace.waddr", {27'b0, inst_trace.waddr}, {27'b0, exp.waddr});
      if (exp.wen) begin
        check_value("inst_trace.wdata", inst_trace.wdata, exp.wdata);
      end
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== filelist.f ====
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/alu_stage.sv
logic/commit_stage.sv
logic/blimp_core.sv
tb/tb_clock_gen.sv
tb/blimp_core_tb.sv
